//--- Makefile
# Verilator simulation of the RV64 single-cycle core testbench.
# Any variable can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FLIST     ?= all.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# The pass message in the log decides the exit status.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- all.f
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_exec.sv
rv_core.sv
rv_core_chk.sv
tb_rv_monitor.sv
tb_rv_core.sv

//--- rv_core.sv
// --------------------------------------------------------------------------
// Single-cycle RV64 core top. PC, run state and the datapath instances.
// Instruction port is combinational and stores are one-cycle strobes.
// --------------------------------------------------------------------------
`default_nettype none

module rv_core
  import rv_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            rst_n,
  output      logic [XLEN-1:0] inst_addr,  // Fetch address, equals pc.
  input  wire logic [ILEN-1:0] inst,       // Returned in the same cycle.
  output      logic            mem_wen,    // Store strobe.
  output      store_t          store,      // Valid while mem_wen is high.
  output      logic            halted,     // EBREAK retired.
  output      logic            trap        // Unknown encoding seen.
);

  // --------------------------------------------------------------------------
  // State
  // --------------------------------------------------------------------------
  logic [XLEN-1:0] pc;
  core_state_e     state;
  logic            run;

  assign run = (state == ST_RUN);

  // Datapath nets.
  dec_t            dec;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] rd_val;
  logic [XLEN-1:0] next_pc;
  store_t          store_req;
  logic            reg_wen;

  // Nothing changes architecturally once stopped.
  assign reg_wen = dec.reg_wen & run;

  // --------------------------------------------------------------------------
  // Datapath
  // --------------------------------------------------------------------------
  rv_decoder u_decoder (
    .inst (inst),
    .dec  (dec)
  );

  rv_regfile u_regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs1     (dec.rs1),
    .rs2     (dec.rs2),
    .wen     (reg_wen),
    .rd      (dec.rd),
    .rd_val  (rd_val),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val)
  );

  rv_exec u_exec (
    .pc        (pc),
    .dec       (dec),
    .rs1_val   (rs1_val),
    .rs2_val   (rs2_val),
    .rd_val    (rd_val),
    .next_pc   (next_pc),
    .store_req (store_req)
  );

  // --------------------------------------------------------------------------
  // PC and run state
  // --------------------------------------------------------------------------
  // EBREAK and not_impl are exclusive by decode. The PC stays on the
  // stopping instruction so inst_addr shows where the core ended.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc    <= RESET_PC;
      state <= ST_RUN;
    end else if (run) begin
      if (dec.is_ebreak) begin
        state <= ST_HALT;          // Halt on breakpoint.
      end else if (dec.not_impl) begin
        state <= ST_TRAP;          // Stop without side effects.
      end else begin
        pc <= next_pc;             // Normal retire.
      end
    end
  end

  // Outputs.
  assign inst_addr = pc;
  assign mem_wen   = dec.mem_wen & run;   // One level per presented SD.
  assign store     = store_req;
  assign halted    = (state == ST_HALT);
  assign trap      = (state == ST_TRAP);

endmodule : rv_core

`default_nettype wire

//--- rv_core_chk.sv
// --------------------------------------------------------------------------
// Concurrent assertions on the control outputs of rv_core, bound into it.
// --------------------------------------------------------------------------
`default_nettype none

module rv_core_chk
  import rv_pkg::*;
(
  input wire logic            clk,
  input wire logic            rst_n,
  input wire logic            mem_wen,
  input wire logic            halted,
  input wire logic            trap,
  input wire logic [XLEN-1:0] pc      // Internal PC of the core.
);
  timeunit 1ns;
  timeprecision 1ps;

  // No store once the core has stopped.
  a_no_store_stopped: assert property (@(posedge clk) disable iff (!rst_n)
    mem_wen |-> !(halted || trap)) else $error("store while stopped");

  // The two stop states exclude each other.
  a_stop_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    !(halted && trap)) else $error("halted and trap both high");

  // PC frozen after EBREAK.
  a_pc_frozen: assert property (@(posedge clk) disable iff (!rst_n)
    halted |=> $stable(pc)) else $error("pc moved while halted");

  // Quiet outputs while reset holds the core.
  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |-> (!mem_wen && !trap && !halted)) else $error("outputs active in reset");

endmodule : rv_core_chk

bind rv_core rv_core_chk u_chk (
  .clk     (clk),
  .rst_n   (rst_n),
  .mem_wen (mem_wen),
  .halted  (halted),
  .trap    (trap),
  .pc      (pc)
);

`default_nettype wire

//--- rv_decoder.sv
// --------------------------------------------------------------------------
// Combinational instruction decoder for ADDI, AUIPC, JAL, SD and EBREAK.
// Any other encoding raises not_impl.
// --------------------------------------------------------------------------
`default_nettype none

module rv_decoder
  import rv_pkg::*;
(
  input  wire logic [ILEN-1:0] inst,  // Raw instruction word.
  output dec_t                 dec    // Decoded fields and controls.
);

  // --------------------------------------------------------------------------
  // Field extraction
  // --------------------------------------------------------------------------
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [11:0] funct12;

  assign opcode  = inst[6:0];
  assign funct3  = inst[14:12];
  assign funct12 = inst[31:20];   // Only meaningful for SYSTEM.

  // Major opcode matches.
  logic op_imm;
  logic op_auipc;
  logic op_jal;
  logic op_store;
  logic op_system;

  assign op_imm    = (opcode == OP_IMM);
  assign op_auipc  = (opcode == AUIPC);
  assign op_jal    = (opcode == JAL);
  assign op_store  = (opcode == STORE);
  assign op_system = (opcode == SYSTEM);

  // --------------------------------------------------------------------------
  // Instruction match
  // --------------------------------------------------------------------------
  logic addi;
  logic auipc;
  logic jal;
  logic sd;
  logic ebreak;

  assign addi   = op_imm & (funct3 == F3_ADDI);
  assign auipc  = op_auipc;                          // U-type has no minor field.
  assign jal    = op_jal;
  assign sd     = op_store & (funct3 == F3_SD);
  assign ebreak = op_system & (funct3 == F3_PRIV) & (funct12 == F12_EBREAK);

  // --------------------------------------------------------------------------
  // Immediate generation
  // --------------------------------------------------------------------------
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_s;

  // Sign bit is always inst[31].
  assign imm_i = {{(XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_u = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{(XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                  inst[30:21], 1'b0};                // Halfword aligned offset.
  assign imm_s = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};

  // One-hot AND-OR select, zero when nothing matches.
  logic [XLEN-1:0] imm;

  assign imm = ({XLEN{addi}}  & imm_i) |
               ({XLEN{auipc}} & imm_u) |
               ({XLEN{jal}}   & imm_j) |
               ({XLEN{sd}}    & imm_s);

  // --------------------------------------------------------------------------
  // Output bundle
  // --------------------------------------------------------------------------
  always_comb begin
    dec.rd        = inst[11:7];
    dec.rs1       = inst[19:15];
    dec.rs2       = inst[24:20];    // Store data source for SD.
    dec.imm       = imm;

    // Adder controls.
    dec.need_imm  = addi | auipc | sd;
    dec.alu_add   = addi | auipc | sd;
    dec.is_auipc  = auipc;
    dec.is_jal    = jal;
    dec.is_ebreak = ebreak;

    // Side effects. SD and EBREAK write no register.
    dec.reg_wen   = addi | auipc | jal;
    dec.mem_wen   = sd;

    // Everything outside the five instructions stops the core.
    dec.not_impl  = ~(addi | auipc | jal | sd | ebreak);
  end

endmodule : rv_decoder

`default_nettype wire

//--- rv_exec.sv
// --------------------------------------------------------------------------
// Execute stage. Adder, JAL link and target, next PC and store request.
// Purely combinational, fed by the decoder and the register file.
// --------------------------------------------------------------------------
`default_nettype none

module rv_exec
  import rv_pkg::*;
(
  input  wire logic [XLEN-1:0] pc,         // Address of the current instruction.
  input  wire dec_t            dec,        // Decoded instruction.
  input  wire logic [XLEN-1:0] rs1_val,
  input  wire logic [XLEN-1:0] rs2_val,
  output      logic [XLEN-1:0] rd_val,     // Write-back value.
  output      logic [XLEN-1:0] next_pc,    // PC for the following cycle.
  output      store_t          store_req   // Address, data and byte mask.
);

  // --------------------------------------------------------------------------
  // Main adder
  // --------------------------------------------------------------------------
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] alu_res;

  assign op_a    = dec.is_auipc ? pc : rs1_val;     // AUIPC adds to pc.
  assign op_b    = dec.need_imm ? dec.imm : rs2_val;
  assign sum     = op_a + op_b;                     // Wraps, no overflow trap.
  assign alu_res = {XLEN{dec.alu_add}} & sum;

  // --------------------------------------------------------------------------
  // Control flow
  // --------------------------------------------------------------------------
  logic [XLEN-1:0] link;
  logic [XLEN-1:0] target;

  assign link   = pc + INST_BYTES;   // Sequential PC, also the JAL link.
  assign target = pc + dec.imm;      // PC-relative jump target.

  assign next_pc = dec.is_jal ? target : link;

  // JAL writes the return address, others the adder result.
  assign rd_val = dec.is_jal ? link : alu_res;

  // --------------------------------------------------------------------------
  // Store request
  // --------------------------------------------------------------------------
  // SD only. Full doubleword, so all byte lanes enabled.
  always_comb begin
    store_req.addr  = alu_res;                     // rs1 + S-immediate.
    store_req.data  = rs2_val;
    store_req.wmask = {WMASK_W{dec.mem_wen}};      // 0xFF for a store, else 0.
  end

endmodule : rv_exec

`default_nettype wire

//--- rv_pkg.sv
// --------------------------------------------------------------------------
// Shared widths, encodings and bundles of the RV64 single-cycle core.
// Import with a wildcard in the module header of each user.
// --------------------------------------------------------------------------
`default_nettype none

package rv_pkg;

  // --------------------------------------------------------------------------
  // Widths and constants
  // --------------------------------------------------------------------------
  localparam int unsigned XLEN     = 64;        // Integer register width.
  localparam int unsigned ILEN     = 32;        // Instruction word width.
  localparam int unsigned REG_ID_W = 5;         // Register index width.
  localparam int unsigned WMASK_W  = XLEN / 8;  // One mask bit per data byte.

  localparam logic [XLEN-1:0] RESET_PC   = 64'h0000_0000_8000_0000;  // First fetch.
  localparam logic [XLEN-1:0] INST_BYTES = 64'd4;  // Fixed 32-bit encoding, no RVC.

  // Minor opcode fields of the implemented subset.
  localparam logic [2:0]  F3_ADDI    = 3'b000;
  localparam logic [2:0]  F3_SD      = 3'b011;   // Doubleword store.
  localparam logic [2:0]  F3_PRIV    = 3'b000;   // ECALL/EBREAK group.
  localparam logic [11:0] F12_EBREAK = 12'h001;

  // --------------------------------------------------------------------------
  // Enums
  // --------------------------------------------------------------------------
  // Major opcodes, inst[6:0].
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    STORE  = 7'b0100011,
    SYSTEM = 7'b1110011
  } opcode_e;

  // Core run state.
  typedef enum logic [1:0] {
    ST_RUN  = 2'd0,  // Retiring one instruction per cycle.
    ST_HALT = 2'd1,  // Stopped by EBREAK.
    ST_TRAP = 2'd2   // Stopped by an unknown encoding.
  } core_state_e;

  // --------------------------------------------------------------------------
  // Structs
  // --------------------------------------------------------------------------
  // Decoded instruction, from the decoder to regfile and execute.
  typedef struct packed {
    logic [REG_ID_W-1:0] rd;
    logic [REG_ID_W-1:0] rs1;
    logic [REG_ID_W-1:0] rs2;
    logic [XLEN-1:0]     imm;        // Already sign-extended.
    logic                need_imm;   // Second adder operand is imm, not rs2.
    logic                alu_add;    // Result comes from the adder.
    logic                is_auipc;   // First adder operand is pc.
    logic                is_jal;
    logic                is_ebreak;
    logic                reg_wen;
    logic                mem_wen;
    logic                not_impl;   // Outside the supported subset.
  } dec_t;

  // Store request towards memory.
  typedef struct packed {
    logic [XLEN-1:0]    addr;
    logic [XLEN-1:0]    data;
    logic [WMASK_W-1:0] wmask;       // Byte enables.
  } store_t;

endpackage : rv_pkg

`default_nettype wire

//--- rv_regfile.sv
// --------------------------------------------------------------------------
// Integer register file, 31 x 64 writable plus a constant zero x0.
// Two asynchronous read ports and one clocked write port.
// --------------------------------------------------------------------------
`default_nettype none

module rv_regfile
  import rv_pkg::*;
(
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic [REG_ID_W-1:0] rs1,      // Read index A.
  input  wire logic [REG_ID_W-1:0] rs2,      // Read index B.
  input  wire logic                wen,      // Write strobe, already gated.
  input  wire logic [REG_ID_W-1:0] rd,       // Write index.
  input  wire logic [XLEN-1:0]     rd_val,   // Write data.
  output      logic [XLEN-1:0]     rs1_val,
  output      logic [XLEN-1:0]     rs2_val
);

  // x0 has no storage.
  logic [XLEN-1:0] regs [1:(1<<REG_ID_W)-1];

  // Write port. Index 0 is dropped here.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < (1 << REG_ID_W); i++) begin
        regs[i] <= '0;               // Architectural state starts at zero.
      end
    end else if (wen && (rd != '0)) begin
      regs[rd] <= rd_val;
    end
  end

  // Read ports. New value shows up the cycle after the write edge.
  assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

endmodule : rv_regfile

`default_nettype wire

//--- tb_rv_core.sv
// --------------------------------------------------------------------------
// Testbench top. Serves small programs to rv_core, one per test from reset,
// and collects the monitor results into the final verdict.
// --------------------------------------------------------------------------
`default_nettype none

module tb_rv_core
  import rv_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PROG_DEPTH = 16;   // Words per program.
  localparam int N_TESTS    = 7;
  // Each instruction at most 4 cycles, plus reset and drain per test.
  localparam int LIMIT_CYC  = N_TESTS * (PROG_DEPTH * 4 + 12) + 100;

  logic            clk;
  logic            rst_n;
  logic [XLEN-1:0] inst_addr;
  logic [ILEN-1:0] inst;
  logic            mem_wen;
  store_t          store;
  logic            halted;
  logic            trap;
  logic [XLEN-1:0] off;
  logic [ILEN-1:0] prog [0:PROG_DEPTH-1];
  int              nprog;
  int              errors;
  int              stores;
  int              failed_tests;
  int              passed_tests;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;           // 4 ns period.
  end

  // Program memory, combinational read. Outside the program reads as zero.
  assign off = inst_addr - RESET_PC;
  assign inst = (off < PROG_DEPTH * 4) ? prog[off[5:2]] : 32'h0;

  rv_core DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .inst_addr (inst_addr),
    .inst      (inst),
    .mem_wen   (mem_wen),
    .store     (store),
    .halted    (halted),
    .trap      (trap)
  );

  tb_rv_monitor u_monitor (
    .clk       (clk),
    .rst_n     (rst_n),
    .inst_addr (inst_addr),
    .inst      (inst),
    .mem_wen   (mem_wen),
    .store     (store),
    .halted    (halted),
    .trap      (trap),
    .errors    (errors),
    .stores    (stores)
  );

  // ----------------------------------------------------------------------------
  // Instruction assembly
  // ----------------------------------------------------------------------------
  function automatic logic [31:0] addi_insn(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, OP_IMM};
  endfunction

  function automatic logic [31:0] auipc_insn(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, AUIPC};
  endfunction

  function automatic logic [31:0] jal_insn(input logic [4:0] rd, input logic [20:0] ofs);
    return {ofs[20], ofs[10:1], ofs[11], ofs[19:12], rd, JAL};
  endfunction

  function automatic logic [31:0] sd_insn(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], STORE};
  endfunction

  localparam logic [31:0] EBREAK_W = {12'h001, 5'd0, 3'b000, 5'd0, SYSTEM};
  localparam logic [31:0] ADD_W    = 32'h0042_02B3;   // add x5, x4, x4.

  function automatic logic [4:0] rand_reg();
    return 5'(1 + ($urandom % 31));    // Never x0.
  endfunction

  // ----------------------------------------------------------------------------
  // Test sequencing
  // ----------------------------------------------------------------------------
  task automatic begin_test();
    @(posedge clk);
    rst_n <= 1'b0;
    for (int i = 0; i < PROG_DEPTH; i++) prog[i] <= 32'h0;
    nprog = 0;
  endtask

  task automatic emit(input logic [31:0] w);
    prog[nprog] <= w;
    nprog++;
  endtask

  // Releases reset after 5 cycles and waits for the core to stop.
  task automatic end_test(input string name, input int n_store, input bit want_trap);
    int e0;
    int s0;
    repeat (5) @(posedge clk);
    e0 = errors;
    s0 = stores;
    rst_n <= 1'b1;
    @(posedge clk);
    while (!(halted || trap)) @(posedge clk);
    repeat (4) @(posedge clk);          // Outputs must stay frozen.
    if (trap !== want_trap || halted === want_trap) begin
      failed_tests++;
      $display("FAILED %0t: test %s stopped the wrong way, halted=%b trap=%b", $time,
               name, halted, trap);
    end else if (stores - s0 != n_store) begin
      failed_tests++;
      $display("FAILED %0t: test %s saw %0d stores, expected %0d", $time, name,
               stores - s0, n_store);
    end else if (errors != e0) begin
      failed_tests++;
      $display("FAILED %0t: test %s had %0d mismatches", $time, name, errors - e0);
    end else begin
      passed_tests++;
      $display("PASS %s", name);
    end
  endtask

  initial begin : main
    logic [4:0] r;
    logic [4:0] b;
    rst_n = 1'b0;
    for (int i = 0; i < PROG_DEPTH; i++) begin
      prog[i] = 32'h0;                 // Known fetch data during the first reset.
    end
    failed_tests = 0;
    passed_tests = 0;
    nprog = 0;
    void'($urandom(8));

    // ADDI chains, each result stored.
    begin_test();
    for (int k = 0; k < 4; k++) begin
      r = rand_reg();
      b = rand_reg();
      emit(addi_insn(r, b, 12'($urandom)));
      emit(addi_insn(r, r, 12'($urandom)));
      emit(sd_insn(r, rand_reg(), 12'($urandom)));
    end
    emit(EBREAK_W);
    end_test("addi_chain", 4, 1'b0);

    // AUIPC seen through a store.
    begin_test();
    emit(auipc_insn(5'd5, 20'($urandom)));
    emit(sd_insn(5'd5, 5'd0, 12'h010));
    emit(EBREAK_W);
    end_test("auipc", 1, 1'b0);

    // JAL over two stores, then store the link.
    begin_test();
    emit(addi_insn(5'd2, 5'd0, 12'h7F0));
    emit(jal_insn(5'd1, 21'd12));
    emit(sd_insn(5'd2, 5'd0, 12'h000));    // Skipped.
    emit(sd_insn(5'd2, 5'd0, 12'h008));    // Skipped.
    emit(sd_insn(5'd1, 5'd0, 12'h020));
    emit(EBREAK_W);
    end_test("jal", 1, 1'b0);

    // Writes to x0 are lost.
    begin_test();
    emit(addi_insn(5'd0, 5'd0, 12'($urandom | 1)));
    emit(sd_insn(5'd0, 5'd0, 12'h008));
    emit(EBREAK_W);
    end_test("x0_write", 1, 1'b0);

    // EBREAK stops before the following store.
    begin_test();
    emit(addi_insn(5'd3, 5'd0, 12'h123));
    emit(EBREAK_W);
    emit(sd_insn(5'd3, 5'd0, 12'h000));
    end_test("ebreak", 0, 1'b0);

    // R-type ADD traps, no store behind it.
    begin_test();
    emit(addi_insn(5'd4, 5'd0, 12'h005));
    emit(ADD_W);
    emit(sd_insn(5'd5, 5'd0, 12'h000));
    end_test("not_impl", 0, 1'b1);

    // Fresh start, so x4 and x5 store zero.
    begin_test();
    emit(addi_insn(5'd0, 5'd0, 12'h000));
    emit(sd_insn(5'd5, 5'd0, 12'h000));
    emit(sd_insn(5'd4, 5'd0, 12'h008));
    emit(EBREAK_W);
    end_test("fresh_regs", 2, 1'b0);

    $display("Tests passed %0d, failed %0d, mismatches %0d", passed_tests, failed_tests,
             errors);
    if (failed_tests == 0 && errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog over the whole run.
  initial begin
    repeat (LIMIT_CYC) @(posedge clk);
    $display("Timeout: the core did not stop within %0d cycles", LIMIT_CYC);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule : tb_rv_core

`default_nettype wire

//--- tb_rv_monitor.sv
// --------------------------------------------------------------------------
// Reference ISA model and checker. Steps once per run cycle at the falling
// edge and compares fetch address, store strobe, store and stop flags.
// --------------------------------------------------------------------------
`default_nettype none

module tb_rv_monitor
  import rv_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic [XLEN-1:0] inst_addr,
  input  wire logic [ILEN-1:0] inst,
  input  wire logic            mem_wen,
  input  wire store_t          store,
  input  wire logic            halted,
  input  wire logic            trap,
  output int                   errors,   // Mismatches seen so far.
  output int                   stores    // Stores observed so far.
);
  timeunit 1ns;
  timeprecision 1ps;

  // Expected effect of one instruction.
  typedef struct packed {
    logic [XLEN-1:0]     next_pc;
    logic                reg_wen;
    logic [REG_ID_W-1:0] rd;
    logic [XLEN-1:0]     rd_val;
    logic                mem_wen;
    store_t              st;
    logic                halt;
    logic                trap;
  } step_t;

  logic [XLEN-1:0] mpc;            // Model PC.
  logic [XLEN-1:0] mregs [0:31];   // Model registers, x0 kept at zero.
  core_state_e     mstate;

  initial begin
    errors = 0;
    stores = 0;
  end

  // ----------------------------------------------------------------------------
  // Reference step, straight from the instruction set rules
  // ----------------------------------------------------------------------------
  function automatic step_t step(input logic [XLEN-1:0] pc, input logic [ILEN-1:0] w);
    step_t           r;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm;
    a = mregs[w[19:15]];
    b = mregs[w[24:20]];
    r = '0;
    r.next_pc = pc + 64'd4;
    r.rd = w[11:7];
    case (w[6:0])
      OP_IMM: begin
        if (w[14:12] == 3'b000) begin      // ADDI.
          imm = {{52{w[31]}}, w[31:20]};
          r.reg_wen = 1'b1;
          r.rd_val = a + imm;
        end else begin
          r.trap = 1'b1;
        end
      end
      AUIPC: begin
        imm = {{32{w[31]}}, w[31:12], 12'b0};
        r.reg_wen = 1'b1;
        r.rd_val = pc + imm;
      end
      JAL: begin
        imm = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        r.reg_wen = 1'b1;
        r.rd_val = pc + 64'd4;             // Link.
        r.next_pc = pc + imm;
      end
      STORE: begin
        if (w[14:12] == 3'b011) begin      // SD.
          imm = {{52{w[31]}}, w[31:25], w[11:7]};
          r.mem_wen = 1'b1;
          r.st.addr = a + imm;
          r.st.data = b;
          r.st.wmask = 8'hFF;
        end else begin
          r.trap = 1'b1;
        end
      end
      SYSTEM: begin
        if (w == 32'h0010_0073) r.halt = 1'b1;  // EBREAK.
        else r.trap = 1'b1;
      end
      default: r.trap = 1'b1;
    endcase
    // A stopping instruction has no side effects and keeps the PC.
    if (r.halt || r.trap) begin
      r.next_pc = pc;
      r.reg_wen = 1'b0;
      r.mem_wen = 1'b0;
    end
    return r;
  endfunction

  task automatic mismatch(input string msg);
    errors++;
    $display("FAILED %0t: %s", $time, msg);
  endtask

  // ----------------------------------------------------------------------------
  // Compare at mid-cycle, where every DUT output is settled
  // ----------------------------------------------------------------------------
  always @(negedge clk) begin : compare
    step_t r;
    if (rst_n !== 1'b1) begin          // Unknown reset counts as reset.
      mpc = RESET_PC;
      mstate = ST_RUN;
      for (int i = 0; i < 32; i++) mregs[i] = '0;
    end else begin
      if (halted !== (mstate == ST_HALT) || trap !== (mstate == ST_TRAP))
        mismatch($sformatf("stop flags halted=%b trap=%b, model state %s",
                           halted, trap, mstate.name()));
      if (inst_addr !== mpc)
        mismatch($sformatf("inst_addr %h, expected %h", inst_addr, mpc));
      if (mstate != ST_RUN) begin
        if (mem_wen !== 1'b0) mismatch("mem_wen high after the core stopped");
      end else begin
        r = step(mpc, inst);
        if (mem_wen !== r.mem_wen)
          mismatch($sformatf("mem_wen %b, expected %b", mem_wen, r.mem_wen));
        else if (r.mem_wen && store !== r.st)
          mismatch($sformatf("store %h/%h/%h, expected %h/%h/%h", store.addr,
                             store.data, store.wmask, r.st.addr, r.st.data, r.st.wmask));
        if (mem_wen === 1'b1) stores++;
        if (r.reg_wen && r.rd != '0) mregs[r.rd] = r.rd_val;   // x0 stays zero.
        mpc = r.next_pc;
        if (r.halt) mstate = ST_HALT;
        else if (r.trap) mstate = ST_TRAP;
      end
    end
  end

endmodule : tb_rv_monitor

`default_nettype wire
